// File: src/mfpu_defines.svh
`ifndef MFPU_DEFINES_SVH
`define MFPU_DEFINES_SVH

// Datapath word and its byte enables
`define MFPU_ELEN 64
`define MFPU_STRB_W 8

// In-flight instructions and buffered results
`define MFPU_INSN_DEPTH 4
`define MFPU_RES_DEPTH 2

// Instruction ids and vector length
`define MFPU_NR_VINSN 8
`define MFPU_VLEN_W 8
`define MFPU_VREG_WORDS 32

// Pipeline registers per SIMD multiplier
`define MFPU_MUL_LAT_EW64 2
`define MFPU_MUL_LAT_EW32 1
`define MFPU_MUL_LAT_EW16 1
`define MFPU_MUL_LAT_EW8 1

`endif

// File: src/mfpu_pkg.sv
`include "mfpu_defines.svh"

package mfpu_pkg;

  // Element width, log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Integer multiply operations
  typedef enum logic [2:0] {
    VMUL,
    VMULH,
    VMULHU,
    VMULHSU,
    VMACC,
    VNMSAC
  } mul_op_e;

  typedef logic [`MFPU_ELEN-1:0]                      elen_t;
  typedef logic [`MFPU_STRB_W-1:0]                    strb_t;
  typedef logic [$clog2(`MFPU_NR_VINSN)-1:0]          vid_t;
  typedef logic [$clog2(32*`MFPU_VREG_WORDS)-1:0]     vaddr_t;
  typedef logic [`MFPU_VLEN_W-1:0]                    vlen_t;

  // One instruction as handed over by the sequencer
  typedef struct packed {
    vid_t       id;
    mul_op_e    op;
    vew_e       vsew;
    vlen_t      vl;
    logic [4:0] vd;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd_op;
    // Operand a comes from the scalar instead of vs1
    logic       use_scalar_op;
    elen_t      scalar_op;
  } mfpu_insn_t;

  // One register file write
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } mfpu_result_t;

  function automatic logic [3:0] elems_per_word(vew_e vsew);
    return 4'd8 >> vsew;
  endfunction

  // Elements carried by the next word, capped at a full word
  function automatic vlen_t word_elems(vlen_t remaining, vew_e vsew);
    vlen_t epw;
    epw = vlen_t'(elems_per_word(vsew));
    return (remaining < epw) ? remaining : epw;
  endfunction

  // Low byte enables covering n elements
  function automatic strb_t word_be(vlen_t n, vew_e vsew);
    int unsigned nbytes;
    strb_t       be;
    nbytes = int'(n) << int'(vsew);
    for (int unsigned b = 0; b < `MFPU_STRB_W; b++) begin
      be[b] = (b < nbytes);
    end
    return be;
  endfunction

endpackage

// File: src/mfpu_insn_tracker.sv
`include "mfpu_defines.svh"

module mfpu_insn_tracker import mfpu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  mfpu_insn_t insn_i,
  input  logic       accept_i,
  input  logic       issue_fire_i,
  input  logic       process_fire_i,
  input  logic       commit_fire_i,
  output logic       full_o,
  output mfpu_insn_t issue_insn_o,
  output logic       issue_valid_o,
  output vlen_t      issue_remaining_o,
  output mfpu_insn_t proc_insn_o,
  output vlen_t      proc_remaining_o,
  output mfpu_insn_t commit_insn_o,
  output logic       commit_valid_o,
  output logic       commit_done_o
);

  localparam int unsigned Depth = `MFPU_INSN_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  // Depth is a power of two, pointers wrap by themselves
  typedef logic [PtrW-1:0]        ptr_t;
  typedef logic [PtrW:0]          cnt_t;
  typedef mfpu_insn_t [Depth-1:0] ring_t;

  // Per phase: head pointer, instructions waiting, elements left of the head
  typedef struct packed {
    ptr_t  pnt;
    cnt_t  cnt;
    vlen_t rem;
  } phase_t;

  ring_t  insn_q;
  ptr_t   accept_pnt_q;
  phase_t issue_q, issue_d;
  phase_t proc_q, proc_d;
  phase_t commit_q, commit_d;

  // One word's worth of elements leaves the phase
  function automatic phase_t phase_step(phase_t ph, ring_t ring);
    phase_t nxt;
    nxt     = ph;
    nxt.rem = ph.rem - word_elems(ph.rem, ring[ph.pnt].vsew);
    if (nxt.rem == '0) begin
      // Head is finished, move on and load the next vl
      nxt.pnt = ph.pnt + ptr_t'(1);
      nxt.cnt = ph.cnt - cnt_t'(1);
      if (nxt.cnt != '0) begin
        nxt.rem = ring[nxt.pnt].vl;
      end
    end
    return nxt;
  endfunction

  // New instruction joins the phase, it becomes the head if the phase is idle
  function automatic phase_t phase_accept(phase_t ph, vlen_t vl);
    phase_t nxt;
    nxt = ph;
    if (ph.cnt == '0) begin
      nxt.rem = vl;
    end
    nxt.cnt = ph.cnt + cnt_t'(1);
    return nxt;
  endfunction

  always_comb begin
    issue_d  = issue_fire_i ? phase_step(issue_q, insn_q) : issue_q;
    proc_d   = process_fire_i ? phase_step(proc_q, insn_q) : proc_q;
    commit_d = commit_fire_i ? phase_step(commit_q, insn_q) : commit_q;
    if (accept_i) begin
      issue_d  = phase_accept(issue_d, insn_i.vl);
      proc_d   = phase_accept(proc_d, insn_i.vl);
      commit_d = phase_accept(commit_d, insn_i.vl);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q       <= '0;
      accept_pnt_q <= '0;
      issue_q      <= '0;
      proc_q       <= '0;
      commit_q     <= '0;
    end else begin
      if (accept_i) begin
        insn_q[accept_pnt_q] <= insn_i;
        accept_pnt_q         <= accept_pnt_q + ptr_t'(1);
      end
      issue_q  <= issue_d;
      proc_q   <= proc_d;
      commit_q <= commit_d;
    end
  end

  // Commit is the last phase, so its count is everything in flight
  assign full_o = (commit_q.cnt == cnt_t'(Depth));

  assign issue_insn_o      = insn_q[issue_q.pnt];
  assign issue_valid_o     = (issue_q.cnt != '0);
  assign issue_remaining_o = issue_q.rem;
  assign proc_insn_o       = insn_q[proc_q.pnt];
  assign proc_remaining_o  = proc_q.rem;
  assign commit_insn_o     = insn_q[commit_q.pnt];
  assign commit_valid_o    = (commit_q.cnt != '0);

  // Final word of the commit head
  assign commit_done_o = commit_fire_i &&
                         (word_elems(commit_q.rem, commit_insn_o.vsew) == commit_q.rem);

endmodule

// File: src/simd_mul.sv
`include "mfpu_defines.svh"

module simd_mul import mfpu_pkg::*; #(
  parameter int unsigned NumPipeRegs  = 1,
  parameter vew_e        ElementWidth = EW64
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  elen_t   operand_c_i,
  input  mul_op_e op_i,
  input  logic    valid_i,
  output logic    ready_o,
  output elen_t   result_o,
  output logic    valid_o,
  input  logic    ready_i
);

  // Lane width in bits and lanes per word
  localparam int unsigned EW    = 8 << ElementWidth;
  localparam int unsigned Lanes = `MFPU_ELEN / EW;

  typedef struct packed {
    elen_t   a;
    elen_t   b;
    elen_t   c;
    mul_op_e op;
  } stage_t;

  // Index i is the input of register i, index NumPipeRegs the pipeline output
  stage_t [NumPipeRegs:0] stage_d;
  logic   [NumPipeRegs:0] valid_d;
  logic   [NumPipeRegs:0] stage_ready;

  assign stage_d[0] = '{a: operand_a_i, b: operand_b_i, c: operand_c_i, op: op_i};
  assign valid_d[0] = valid_i;
  assign ready_o    = stage_ready[0];

  // Back-pressure enters at the output
  assign stage_ready[NumPipeRegs] = ready_i;
  assign valid_o                  = valid_d[NumPipeRegs];

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic   valid_q;
    stage_t data_q;

    // Load when empty or when the downstream stage takes our item
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= valid_d[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && valid_d[i]) begin
        data_q <= stage_d[i];
      end
    end

    assign valid_d[i+1] = valid_q;
    assign stage_d[i+1] = data_q;
  end

  stage_t st_out;
  logic   signed_a;
  logic   signed_b;

  assign st_out = stage_d[NumPipeRegs];

  // Operand signedness for the high half, a is vs1 and b is vs2
  assign signed_a = (st_out.op == VMULH);
  assign signed_b = st_out.op inside {VMULH, VMULHSU};

  for (genvar l = 0; l < Lanes; l++) begin : gen_lane
    logic [EW-1:0]   a;
    logic [EW-1:0]   b;
    logic [EW-1:0]   c;
    logic [EW-1:0]   res;
    logic [2*EW-1:0] prod;

    assign a = st_out.a[l*EW +: EW];
    assign b = st_out.b[l*EW +: EW];
    assign c = st_out.c[l*EW +: EW];

    // One extra bit picks signed or unsigned, 2*EW bits hold the full product
    assign prod = $signed({signed_a & a[EW-1], a}) * $signed({signed_b & b[EW-1], b});

    always_comb begin
      case (st_out.op)
        VMUL:                   res = prod[EW-1:0];
        VMULH, VMULHU, VMULHSU: res = prod[2*EW-1:EW];
        VMACC:                  res = prod[EW-1:0] + c;
        VNMSAC:                 res = c - prod[EW-1:0];
        default:                res = '0;
      endcase
    end

    assign result_o[l*EW +: EW] = res;
  end

endmodule

// File: src/mfpu_result_queue.sv
`include "mfpu_defines.svh"

module mfpu_result_queue import mfpu_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         push_i,
  input  mfpu_result_t push_data_i,
  output logic         full_o,
  output mfpu_result_t result_o,
  output logic         result_req_o,
  input  logic         result_gnt_i,
  output logic         pop_o
);

  localparam int unsigned Depth = `MFPU_RES_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  mfpu_result_t [Depth-1:0] mem_q;
  logic [PtrW-1:0]          wr_pnt_q;
  logic [PtrW-1:0]          rd_pnt_q;
  logic [PtrW:0]            cnt_q;
  logic                     push;

  assign full_o = (cnt_q == (PtrW+1)'(Depth));
  assign push   = push_i && !full_o;

  // Head entry is the pending register file write
  assign result_req_o = (cnt_q != '0);
  assign result_o     = mem_q[rd_pnt_q];
  assign pop_o        = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= (wr_pnt_q == PtrW'(Depth-1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop_o) begin
        rd_pnt_q <= (rd_pnt_q == PtrW'(Depth-1)) ? '0 : rd_pnt_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push && !pop_o) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_o && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= push_data_i;
    end
  end

endmodule

// File: src/mfpu.sv
`include "mfpu_defines.svh"

module mfpu import mfpu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  mfpu_insn_t                insn_i,
  input  logic                      insn_valid_i,
  output logic                      ready_o,
  input  elen_t [2:0]               operand_i,
  input  logic  [2:0]               operand_valid_i,
  output logic  [2:0]               operand_ready_o,
  output mfpu_result_t              result_o,
  output logic                      result_req_o,
  input  logic                      result_gnt_i,
  output logic [`MFPU_NR_VINSN-1:0] vinsn_done_o
);

  // Multiplier depth indexed by element width
  localparam int unsigned MulLat [4] = '{`MFPU_MUL_LAT_EW8, `MFPU_MUL_LAT_EW16,
                                         `MFPU_MUL_LAT_EW32, `MFPU_MUL_LAT_EW64};

  mfpu_insn_t   issue_insn, proc_insn, commit_insn;
  logic         issue_valid, commit_valid, commit_done, full;
  vlen_t        issue_remaining, proc_remaining, proc_elems;
  logic         issue_fire, process_fire, commit_fire;
  logic         ops_valid, res_full, res_pop;
  elen_t        scalar_op, operand_a;
  elen_t [3:0]  mul_result;
  logic  [3:0]  mul_in_valid, mul_in_ready, mul_out_valid, mul_out_ready;
  mfpu_result_t push_data;

  assign ready_o = !full;

  mfpu_insn_tracker i_tracker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .insn_i           (insn_i),
    .accept_i         (insn_valid_i && !full),
    .issue_fire_i     (issue_fire),
    .process_fire_i   (process_fire),
    .commit_fire_i    (commit_fire),
    .full_o           (full),
    .issue_insn_o     (issue_insn),
    .issue_valid_o    (issue_valid),
    .issue_remaining_o(issue_remaining),
    .proc_insn_o      (proc_insn),
    .proc_remaining_o (proc_remaining),
    .commit_insn_o    (commit_insn),
    .commit_valid_o   (commit_valid),
    .commit_done_o    (commit_done)
  );

  // Scalar copied into every lane of the word
  always_comb begin
    case (issue_insn.vsew)
      EW8:     scalar_op = {8{issue_insn.scalar_op[7:0]}};
      EW16:    scalar_op = {4{issue_insn.scalar_op[15:0]}};
      EW32:    scalar_op = {2{issue_insn.scalar_op[31:0]}};
      default: scalar_op = issue_insn.scalar_op;
    endcase
  end

  assign operand_a = issue_insn.use_scalar_op ? scalar_op : operand_i[0];

  // All operands the head instruction reads are present
  assign ops_valid = issue_valid && (issue_remaining != '0) &&
                     (operand_valid_i[0] || !issue_insn.use_vs1) &&
                     (operand_valid_i[1] || !issue_insn.use_vs2) &&
                     (operand_valid_i[2] || !issue_insn.use_vd_op);

  for (genvar w = 0; w < 4; w++) begin : gen_mul
    simd_mul #(
      .NumPipeRegs (MulLat[w]),
      .ElementWidth(vew_e'(w))
    ) i_simd_mul (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .operand_a_i(operand_a),
      .operand_b_i(operand_i[1]),
      .operand_c_i(operand_i[2]),
      .op_i       (issue_insn.op),
      .valid_i    (mul_in_valid[w]),
      .ready_o    (mul_in_ready[w]),
      .result_o   (mul_result[w]),
      .valid_o    (mul_out_valid[w]),
      .ready_i    (mul_out_ready[w])
    );
  end

  // Issue into the issue width, drain in order from the processing width
  always_comb begin
    mul_in_valid                  = '0;
    mul_in_valid[issue_insn.vsew] = ops_valid;
    mul_out_ready                 = '0;
    mul_out_ready[proc_insn.vsew] = !res_full;
  end

  assign issue_fire      = ops_valid && mul_in_ready[issue_insn.vsew];
  assign process_fire    = mul_out_valid[proc_insn.vsew] && !res_full;
  assign operand_ready_o = issue_fire ?
                           {issue_insn.use_vd_op, issue_insn.use_vs2, issue_insn.use_vs1} : 3'b000;

  // Word index is the elements already processed over elements per word
  assign proc_elems = word_elems(proc_remaining, proc_insn.vsew);

  always_comb begin
    push_data.id    = proc_insn.id;
    push_data.addr  = vaddr_t'(proc_insn.vd) * vaddr_t'(`MFPU_VREG_WORDS) +
                      vaddr_t'((proc_insn.vl - proc_remaining) >>
                               (int'(EW64) - int'(proc_insn.vsew)));
    push_data.wdata = mul_result[proc_insn.vsew];
    push_data.be    = word_be(proc_elems, proc_insn.vsew);
  end

  mfpu_result_queue i_result_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (process_fire),
    .push_data_i (push_data),
    .full_o      (res_full),
    .result_o    (result_o),
    .result_req_o(result_req_o),
    .result_gnt_i(result_gnt_i),
    .pop_o       (res_pop)
  );

  assign commit_fire = res_pop && commit_valid;

  // Done pulse in the grant cycle of the last word
  always_comb begin
    vinsn_done_o = '0;
    if (commit_done) begin
      vinsn_done_o[commit_insn.id] = 1'b1;
    end
  end

endmodule

// File: tests/mfpu_asserts.sv
`include "mfpu_defines.svh"

module mfpu_asserts import mfpu_pkg::*; (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      insn_valid_i,
  input logic                      ready_o,
  input mfpu_result_t              result_o,
  input logic                      result_req_o,
  input logic                      result_gnt_i,
  input logic [`MFPU_NR_VINSN-1:0] vinsn_done_o
);

  int unsigned fail_cnt = 0;
  logic [2:0]  inflight_q;

  // Instructions between acceptance and their done pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + 3'(insn_valid_i && ready_o) - 3'(|vinsn_done_o);
    end
  end

  idle_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !result_req_o && ready_o && vinsn_done_o == '0)
    else begin
      $error("Request, done or busy seen while in reset");
      fail_cnt++;
    end

  // Held request keeps its data until the grant
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_o))
    else begin
      $error("Result request dropped or changed before its grant");
      fail_cnt++;
    end

  // Done pulse sits on the id of the word being granted, one bit only
  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vinsn_done_o != '0 |-> result_req_o && result_gnt_i &&
      (vinsn_done_o == (`MFPU_NR_VINSN'(1) << result_o.id)))
    else begin
      $error("Done pulse is not one-hot on the granted instruction id");
      fail_cnt++;
    end

  ready_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ready_o == (inflight_q != 3'(`MFPU_INSN_DEPTH)))
    else begin
      $error("Instruction ready does not match the in-flight count");
      fail_cnt++;
    end

endmodule

bind mfpu mfpu_asserts i_mfpu_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .insn_valid_i(insn_valid_i),
  .ready_o     (ready_o),
  .result_o    (result_o),
  .result_req_o(result_req_o),
  .result_gnt_i(result_gnt_i),
  .vinsn_done_o(vinsn_done_o)
);

// File: tests/mfpu_tb.sv
`include "mfpu_defines.svh"

module mfpu_tb import mfpu_pkg::*; ();

  localparam int unsigned NumInsn     = 36;
  localparam int unsigned ResetCycles = 10;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  mfpu_insn_t                insn;
  logic                      insn_valid;
  logic                      ready;
  elen_t [2:0]               operand;
  logic  [2:0]               operand_valid;
  logic  [2:0]               operand_ready;
  mfpu_result_t              result;
  logic                      result_req;
  logic                      result_gnt;
  logic [`MFPU_NR_VINSN-1:0] vinsn_done;

  int    seed = 32'h48dd;
  int    data_errs = 0;
  int    done_errs = 0;
  int    flow_errs = 0;
  vid_t  next_id;
  string test_name;
  bit    slow_gnt;
  bit    ready_dropped;

  // Operand words per port, expected writes in order, expected done ids
  elen_t        op_q [3][$];
  mfpu_result_t exp_q[$];
  string        exp_name_q[$];
  vid_t         done_q[$];

  always #2 clk_i = ~clk_i;

  mfpu uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn),
    .insn_valid_i   (insn_valid),
    .ready_o        (ready),
    .operand_i      (operand),
    .operand_valid_i(operand_valid),
    .operand_ready_o(operand_ready),
    .result_o       (result),
    .result_req_o   (result_req),
    .result_gnt_i   (result_gnt),
    .vinsn_done_o   (vinsn_done)
  );

  // Reference multiply, lane by lane with 128-bit products
  function automatic elen_t model_word(mul_op_e op, vew_e vsew, elen_t a, elen_t b, elen_t c);
    int unsigned  ew;
    logic [127:0] xa, xb, lc, p, mask;
    logic [63:0]  r;
    elen_t        res;
    ew   = 8 << vsew;
    mask = (128'd1 << ew) - 128'd1;
    res  = '0;
    for (int unsigned l = 0; l < 64 / ew; l++) begin
      xa = (128'(a) >> (l * ew)) & mask;
      xb = (128'(b) >> (l * ew)) & mask;
      lc = (128'(c) >> (l * ew)) & mask;
      // vs1 signed only for VMULH, vs2 signed for VMULH and VMULHSU
      if (op == VMULH && xa[ew-1]) begin
        xa = xa | (~128'd0 << ew);
      end
      if ((op == VMULH || op == VMULHSU) && xb[ew-1]) begin
        xb = xb | (~128'd0 << ew);
      end
      p = xa * xb;
      case (op)
        VMULH, VMULHU, VMULHSU: r = 64'((p >> ew) & mask);
        VMACC:                  r = 64'((p + lc) & mask);
        VNMSAC:                 r = 64'((lc - p) & mask);
        default:                r = 64'(p & mask);
      endcase
      res = res | (elen_t'(r) << (l * ew));
    end
    return res;
  endfunction

  // Builds one instruction with its operand words and expected writes, then offers it
  task automatic send_insn(input mul_op_e op, input vew_e vsew, input int unsigned vl,
                           input bit scalar, input bit sign_fill);
    mfpu_insn_t   in;
    mfpu_result_t want;
    elen_t        a, b, c, rep, sign_mask, lane_mask;
    int unsigned  ew, epw, words, nel;
    ew               = 8 << vsew;
    epw              = 64 / ew;
    words            = (vl + epw - 1) / epw;
    in               = '0;
    in.id            = next_id;
    in.op            = op;
    in.vsew          = vsew;
    in.vl            = vlen_t'(vl);
    in.vd            = 5'($random(seed));
    in.use_vs1       = !scalar;
    in.use_vs2       = 1'b1;
    in.use_vd_op     = op inside {VMACC, VNMSAC};
    in.use_scalar_op = scalar;
    in.scalar_op     = {$random(seed), $random(seed)};
    lane_mask        = (64'd1 << ew) - 64'd1;
    rep              = '0;
    sign_mask        = '0;
    for (int unsigned l = 0; l < epw; l++) begin
      rep                     = rep | ((in.scalar_op & lane_mask) << (l * ew));
      sign_mask[l * ew + ew - 1] = 1'b1;
    end
    for (int unsigned w = 0; w < words; w++) begin
      a = scalar ? rep : {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      c = {$random(seed), $random(seed)};
      // Every other word gets the sign bit in each lane
      if (sign_fill && w % 2 == 0) begin
        a = scalar ? a : (a | sign_mask);
        b = b | sign_mask;
      end
      if (in.use_vs1) op_q[0].push_back(a);
      op_q[1].push_back(b);
      if (in.use_vd_op) op_q[2].push_back(c);
      nel        = (vl - w * epw < epw) ? vl - w * epw : epw;
      want.id    = in.id;
      want.addr  = vaddr_t'(in.vd) * vaddr_t'(`MFPU_VREG_WORDS) + vaddr_t'(w);
      want.wdata = model_word(op, vsew, a, b, c);
      want.be    = strb_t'((9'd1 << (nel * ew / 8)) - 9'd1);
      exp_q.push_back(want);
      exp_name_q.push_back(test_name);
    end
    done_q.push_back(in.id);
    @(negedge clk_i);
    insn       = in;
    insn_valid = 1'b1;
    do @(posedge clk_i); while (!ready);
    next_id = next_id + vid_t'(1);
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    insn_valid = 1'b0;
    while (exp_q.size() != 0 || done_q.size() != 0) @(negedge clk_i);
  endtask

  // One feeder per operand port, with random gaps in valid
  for (genvar k = 0; k < 3; k++) begin : gen_feed
    always @(negedge clk_i) begin
      operand_valid[k] = rst_ni && op_q[k].size() != 0 && ($random(seed) & 3) != 0;
      operand[k]       = (op_q[k].size() != 0) ? op_q[k][0] : '0;
    end

    always @(posedge clk_i) begin
      if (rst_ni && operand_valid[k] && operand_ready[k]) begin
        void'(op_q[k].pop_front());
      end
    end
  end

  // Grant is random, sparse while slow_gnt is set
  always @(negedge clk_i) begin
    result_gnt = rst_ni && (slow_gnt ? ($random(seed) & 3) == 0 : ($random(seed) & 3) != 0);
  end

  always @(posedge clk_i) begin : check_outputs
    mfpu_result_t want;
    string        name;
    vid_t         id;
    if (rst_ni && !ready) ready_dropped = 1'b1;
    if (rst_ni && result_req && result_gnt) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected register file write to address %0d", result.addr);
        flow_errs++;
      end else begin
        want = exp_q.pop_front();
        name = exp_name_q.pop_front();
        if (result !== want) begin
          $display("Mismatch %s: expected id %0d addr %0d data %h be %b, ",
                   name, want.id, want.addr, want.wdata, want.be,
                   "actual id %0d addr %0d data %h be %b",
                   result.id, result.addr, result.wdata, result.be);
          data_errs++;
        end
      end
    end
    if (rst_ni && vinsn_done != '0) begin
      if (done_q.size() == 0) begin
        $display("Done pulse %b arrived with no instruction left to finish", vinsn_done);
        flow_errs++;
      end else begin
        id = done_q.pop_front();
        if (vinsn_done !== (`MFPU_NR_VINSN'(1) << id)) begin
          $display("Mismatch %s done: expected %b, actual %b",
                   test_name, `MFPU_NR_VINSN'(1) << id, vinsn_done);
          done_errs++;
        end
      end
    end
  end

  initial begin
    rst_ni        = 1'b0;
    insn          = '0;
    insn_valid    = 1'b0;
    operand       = '0;
    operand_valid = '0;
    result_gnt    = 1'b0;
    next_id       = '0;
    slow_gnt      = 1'b0;
    ready_dropped = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "vmul_vv";
    for (int w = 0; w < 4; w++) send_insn(VMUL, vew_e'(w), 16, 1'b0, 1'b0);
    wait_drain();

    test_name = "mulh_sign";
    for (int w = 0; w < 4; w++) begin
      send_insn(VMULH, vew_e'(w), 16, 1'b0, 1'b1);
      send_insn(VMULHU, vew_e'(w), 16, 1'b0, 1'b1);
      send_insn(VMULHSU, vew_e'(w), 16, 1'b0, 1'b1);
    end
    wait_drain();

    // Accumulates read vd, scalar forms take the replicated scalar as vs1
    test_name = "mac_scalar";
    for (int w = 0; w < 4; w++) begin
      send_insn(VMACC, vew_e'(w), 12, w[0], 1'b0);
      send_insn(VNMSAC, vew_e'(w), 12, !w[0], 1'b0);
      send_insn(VMUL, vew_e'(w), 12, 1'b1, 1'b0);
    end
    wait_drain();

    test_name = "partial_vl";
    send_insn(VMUL, EW16, 13, 1'b0, 1'b0);
    send_insn(VMACC, EW32, 5, 1'b0, 1'b0);
    send_insn(VMULHU, EW8, 3, 1'b0, 1'b0);
    wait_drain();

    test_name     = "back_to_back";
    slow_gnt      = 1'b1;
    ready_dropped = 1'b0;
    for (int i = 0; i < 5; i++) begin
      send_insn(mul_op_e'($unsigned($random(seed)) % 6), vew_e'($random(seed) & 3),
                4 + $unsigned($random(seed)) % 20, $random(seed) & 1, 1'b1);
    end
    wait_drain();
    if (!ready_dropped) begin
      $display("Instruction ready never dropped during back to back issue");
      flow_errs++;
    end

    $display("Errors: data %0d, done %0d, flow %0d, assertion %0d",
             data_errs, done_errs, flow_errs, uut.i_mfpu_asserts.fail_cnt);
    if (data_errs + done_errs + flow_errs + uut.i_mfpu_asserts.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Budget of 200 cycles per instruction on top of reset
  initial begin
    #((ResetCycles + 200 * NumInsn) * 4);
    $display("Timeout after %0d cycles with %0d writes outstanding",
             ResetCycles + 200 * NumInsn, exp_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/mfpu_pkg.sv
src/mfpu_insn_tracker.sv
src/simd_mul.sv
src/mfpu_result_queue.sv
src/mfpu.sv
tests/mfpu_asserts.sv
tests/mfpu_tb.sv

// File: Bender.yml
package:
  name: mfpu

sources:
  - include_dirs:
      - src
    files:
      - src/mfpu_pkg.sv
      - src/mfpu_insn_tracker.sv
      - src/simd_mul.sv
      - src/mfpu_result_queue.sv
      - src/mfpu.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/mfpu_asserts.sv
      - tests/mfpu_tb.sv
